/* rtl/prot_consts.svh */
/*
 protection coprocessor constants
 bus widths, shared window offsets and engine memory map bases
*/
`ifndef PROT_CONSTS_SVH
`define PROT_CONSTS_SVH

`define PROT_AW       21          // engine address bus
`define PROT_DW       8
`define PROT_MAIN_AW  11          // 2kB main window
`define PROT_ROM_AW   9           // 512 byte protection rom
`define PROT_RAM_AW   11
`define PROT_SHD_AW   11

`define PROT_DOORBELL 11'h7ff     // top byte rings the engine
`define PROT_KEY_OFS  11'h000
`define PROT_STAT_OFS 11'h001
`define PROT_RES_OFS  11'h002
`define PROT_DONE     8'ha5

`define PROT_ROM_BASE 21'h00fe00  // engine side bases
`define PROT_RAM_BASE 21'h1f0000
`define PROT_SHD_BASE 21'h1f2000

`endif

/* rtl/prot_pkg.sv */
/*
 protection coprocessor types
 engine bus cycle, main cpu access and rom download beat
*/
`include "prot_consts.svh"

package prot_pkg;

    typedef logic [`PROT_DW-1:0] byte_t;

    // one engine access, rd/wr high for a single cycle
    typedef struct packed {
        logic [`PROT_AW-1:0] addr;
        byte_t               wdata;
        logic                rd;
        logic                wr;
    } prot_bus_t;

    // main cpu side of the shared window
    typedef struct packed {
        logic [`PROT_MAIN_AW-1:0] addr;
        byte_t                    wdata;
        logic                     cs;
        logic                     wrn;   // low for write
    } main_bus_t;

    // rom download beat
    typedef struct packed {
        logic [`PROT_ROM_AW-1:0] addr;
        byte_t                   data;
        logic                    en;
    } prog_t;

endpackage

/* rtl/prot_mem.sv */
/*
 single port synchronous memory
 registered read, write side shared with the same address
 word type is a parameter so rom and work ram use one block
*/
module prot_mem #(
    parameter type word_t = logic [7:0],
    parameter int  AW     = 9
) (
    input  logic          clk,
    input  logic [AW-1:0] addr,
    input  word_t         wdata,
    input  logic          we,
    output word_t         q
);

    word_t mem [2**AW];   // no init, engine clears what it needs

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];   // old data on read during write
    end

endmodule

/* rtl/prot_shared_ram.sv */
/*
 2kB dual port shared ram between main cpu and protection engine
 main port wins colliding writes
 writing the top byte from the main side rings the engine doorbell
*/
`include "prot_consts.svh"

module prot_shared_ram (
    input  logic                     clk,
    input  prot_pkg::main_bus_t      main,
    output prot_pkg::byte_t          main_din,
    input  logic [`PROT_SHD_AW-1:0] eaddr,
    input  prot_pkg::byte_t          ewdata,
    input  logic                     ewe,
    output prot_pkg::byte_t          eq,
    output logic                     doorbell
);

    prot_pkg::byte_t mem [2**`PROT_SHD_AW];

    logic main_we;
    logic clash;     // both sides writing one byte
    logic bell_hit;

    assign main_we  = main.cs & ~main.wrn;
    assign clash    = main_we && ewe && (main.addr == eaddr);
    assign bell_hit = main_we && (main.addr == `PROT_DOORBELL);

    // single process keeps both write ports on one array
    always_ff @(posedge clk) begin
        if (ewe && !clash) begin
            mem[eaddr] <= ewdata;      // engine side
        end
        if (main_we) begin
            mem[main.addr] <= main.wdata;
        end
    end

    // main read port, holds the last byte when not selected
    always_ff @(posedge clk) begin
        if (main.cs) begin
            main_din <= mem[main.addr];
        end
    end

    always_ff @(posedge clk) begin
        eq <= mem[eaddr];              // engine read port
    end

    // one cycle pulse, stands in for the sub cpu irq line
    always_ff @(posedge clk) begin
        doorbell <= bell_hit;
    end

endmodule

/* rtl/prot_decode.sv */
/*
 engine address decode
 rom, work ram and shared ram selects from the 21 bit map,
 write steering and registered read data return
*/
`include "prot_consts.svh"

module prot_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  prot_pkg::prot_bus_t      ebus,
    output prot_pkg::byte_t          edin,
    input  prot_pkg::prog_t          prog,
    output logic [`PROT_ROM_AW-1:0] rom_addr,
    output prot_pkg::byte_t          rom_wdata,
    output logic                     rom_we,
    input  prot_pkg::byte_t          rom_q,
    output logic [`PROT_RAM_AW-1:0] ram_addr,
    output prot_pkg::byte_t          ram_wdata,
    output logic                     ram_we,
    input  prot_pkg::byte_t          ram_q,
    output logic [`PROT_SHD_AW-1:0] shd_addr,
    output prot_pkg::byte_t          shd_wdata,
    output logic                     shd_we,
    input  prot_pkg::byte_t          shd_q
);

    logic rom_sel, ram_sel, shd_sel;
    logic rd_rom, rd_ram, rd_shd;   // region of the read in flight

    always_comb begin
        // 00fe00-00ffff
        rom_sel = (ebus.addr[`PROT_AW-1:16] == '0) && (ebus.addr[15:9] == '1);
        ram_sel = ebus.addr[`PROT_AW-1] & ~ebus.addr[13];   // 1f0000 up
        shd_sel = ebus.addr[`PROT_AW-1] &  ebus.addr[13];   // 1f2000 up
    end

    // rom write side belongs to the download port
    assign rom_addr  = prog.en ? prog.addr : ebus.addr[`PROT_ROM_AW-1:0];
    assign rom_wdata = prog.data;
    assign rom_we    = prog.en;

    assign ram_addr  = ebus.addr[`PROT_RAM_AW-1:0];
    assign ram_wdata = ebus.wdata;
    assign ram_we    = ebus.wr & ram_sel;

    assign shd_addr  = ebus.addr[`PROT_SHD_AW-1:0];
    assign shd_wdata = ebus.wdata;
    assign shd_we    = ebus.wr & shd_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_rom <= 1'b0;
            rd_ram <= 1'b0;
            rd_shd <= 1'b0;
        end else begin
            rd_rom <= ebus.rd & rom_sel;
            rd_ram <= ebus.rd & ram_sel;
            rd_shd <= ebus.rd & shd_sel;
        end
    end

    // memory q valid one cycle after rd, edin one more
    always_ff @(posedge clk) begin
        edin <= rd_ram ? ram_q :
                rd_shd ? shd_q :
                rd_rom ? rom_q : 8'hff;   // open bus
    end

endmodule

/* rtl/prot_engine.sv */
/*
 protection engine sequencer
 clears work ram after reset, then services doorbell queries:
 result = rom[key] + count[key], count[key] incremented, status marked done
*/
`include "prot_consts.svh"

module prot_engine (
    input  logic                clk,
    input  logic                reset,
    input  logic                doorbell,
    output prot_pkg::prot_bus_t ebus,
    input  prot_pkg::byte_t     edin
);

    typedef enum logic [2:0] {
        st_clear,   // zero work ram 0..255
        st_idle,
        st_key,     // key read in flight
        st_rom,     // rom read in flight
        st_cnt,     // count read in flight
        st_res,     // result write on the bus
        st_inc,     // count write on the bus
        st_stat     // status write on the bus
    } state_t;

    state_t          state;
    logic [7:0]      clr_addr;
    logic [1:0]      wcnt;      // read wait, data at 2
    logic            pending;   // doorbells merge here
    logic            rd_done;
    prot_pkg::byte_t key;
    prot_pkg::byte_t rom_byte;
    prot_pkg::byte_t count;

    assign rd_done = (wcnt == 2'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_clear;
            clr_addr <= 8'd0;
            wcnt     <= 2'd0;
            pending  <= 1'b0;
            ebus     <= '0;
        end else begin
            ebus.rd <= 1'b0;   // strobes last one cycle
            ebus.wr <= 1'b0;
            if (doorbell) begin
                pending <= 1'b1;
            end
            case (state)
                st_clear: begin
                    ebus.addr  <= `PROT_RAM_BASE + `PROT_AW'(clr_addr);
                    ebus.wdata <= 8'd0;
                    ebus.wr    <= 1'b1;
                    clr_addr   <= clr_addr + 8'd1;
                    if (clr_addr == 8'hff) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (pending || doorbell) begin
                        pending   <= 1'b0;   // this query covers it
                        ebus.addr <= `PROT_SHD_BASE + `PROT_AW'(`PROT_KEY_OFS);
                        ebus.rd   <= 1'b1;
                        wcnt      <= 2'd0;
                        state     <= st_key;
                    end
                end
                st_key: begin
                    wcnt <= wcnt + 2'd1;
                    if (rd_done) begin
                        // edin is the key this cycle
                        ebus.addr <= `PROT_ROM_BASE + `PROT_AW'(edin);
                        ebus.rd   <= 1'b1;
                        wcnt      <= 2'd0;
                        state     <= st_rom;
                    end
                end
                st_rom: begin
                    wcnt <= wcnt + 2'd1;
                    if (rd_done) begin
                        ebus.addr <= `PROT_RAM_BASE + `PROT_AW'(key);
                        ebus.rd   <= 1'b1;
                        wcnt      <= 2'd0;
                        state     <= st_cnt;
                    end
                end
                st_cnt: begin
                    wcnt <= wcnt + 2'd1;
                    if (rd_done) begin
                        ebus.addr  <= `PROT_SHD_BASE + `PROT_AW'(`PROT_RES_OFS);
                        ebus.wdata <= rom_byte + edin;   // wraps mod 256
                        ebus.wr    <= 1'b1;
                        wcnt       <= 2'd0;
                        state      <= st_res;
                    end
                end
                st_res: begin
                    ebus.addr  <= `PROT_RAM_BASE + `PROT_AW'(key);
                    ebus.wdata <= count + 8'd1;
                    ebus.wr    <= 1'b1;
                    state      <= st_inc;
                end
                st_inc: begin
                    // done marker last, main side polls on it
                    ebus.addr  <= `PROT_SHD_BASE + `PROT_AW'(`PROT_STAT_OFS);
                    ebus.wdata <= `PROT_DONE;
                    ebus.wr    <= 1'b1;
                    state      <= st_stat;
                end
                st_stat: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // query operands, captured when each read lands
    always_ff @(posedge clk) begin
        if (rd_done) begin
            case (state)
                st_key:  key      <= edin;
                st_rom:  rom_byte <= edin;
                st_cnt:  count    <= edin;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/prot_top.sv */
/*
 protection coprocessor top
 engine, address decode, rom, work ram and shared window
*/
`include "prot_consts.svh"

module prot_top (
    input  logic                clk,
    input  logic                reset,
    input  prot_pkg::main_bus_t main,
    output prot_pkg::byte_t     main_din,
    input  prot_pkg::prog_t     prog
);

    prot_pkg::prot_bus_t ebus;
    prot_pkg::byte_t     edin;
    logic                doorbell;

    logic [`PROT_ROM_AW-1:0] rom_addr;
    prot_pkg::byte_t          rom_wdata, rom_q;
    logic                     rom_we;
    logic [`PROT_RAM_AW-1:0] ram_addr;
    prot_pkg::byte_t          ram_wdata, ram_q;
    logic                     ram_we;
    logic [`PROT_SHD_AW-1:0] shd_addr;
    prot_pkg::byte_t          shd_wdata, shd_q;
    logic                     shd_we;

    prot_engine u_engine (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .doorbell ( doorbell ),
        .ebus     ( ebus     ),
        .edin     ( edin     )
    );

    prot_decode u_decode (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .ebus      ( ebus      ),
        .edin      ( edin      ),
        .prog      ( prog      ),
        .rom_addr  ( rom_addr  ),
        .rom_wdata ( rom_wdata ),
        .rom_we    ( rom_we    ),
        .rom_q     ( rom_q     ),
        .ram_addr  ( ram_addr  ),
        .ram_wdata ( ram_wdata ),
        .ram_we    ( ram_we    ),
        .ram_q     ( ram_q     ),
        .shd_addr  ( shd_addr  ),
        .shd_wdata ( shd_wdata ),
        .shd_we    ( shd_we    ),
        .shd_q     ( shd_q     )
    );

    // protection rom, written only by the download port
    prot_mem #(.word_t(prot_pkg::byte_t), .AW(`PROT_ROM_AW)) u_rom (
        .clk   ( clk       ),
        .addr  ( rom_addr  ),
        .wdata ( rom_wdata ),
        .we    ( rom_we    ),
        .q     ( rom_q     )
    );

    prot_mem #(.word_t(prot_pkg::byte_t), .AW(`PROT_RAM_AW)) u_ram (
        .clk   ( clk       ),
        .addr  ( ram_addr  ),
        .wdata ( ram_wdata ),
        .we    ( ram_we    ),
        .q     ( ram_q     )
    );

    prot_shared_ram u_shared (
        .clk      ( clk       ),
        .main     ( main      ),
        .main_din ( main_din  ),
        .eaddr    ( shd_addr  ),
        .ewdata   ( shd_wdata ),
        .ewe      ( shd_we    ),
        .eq       ( shd_q     ),
        .doorbell ( doorbell  )
    );

endmodule

/* test/prot_tb.sv */
/*
 protection coprocessor testbench
 downloads a random rom image, runs key queries and shared window accesses
 from a table, checks results against a rom copy and per key use counts
*/
`include "prot_consts.svh"

module prot_tb;

    localparam int NUM_ROWS   = 20;
    localparam int POLL_LIMIT = 300;   // status reads before giving up

    localparam logic [2:0] OP_LOAD      = 3'd0;   // rom download
    localparam logic [2:0] OP_WRITE     = 3'd1;   // write then read back
    localparam logic [2:0] OP_READ      = 3'd2;
    localparam logic [2:0] OP_QUERY     = 3'd3;
    localparam logic [2:0] OP_RST_QUERY = 3'd4;   // doorbell during the clear

    typedef struct packed {
        logic [2:0]                 op;
        logic [`PROT_MAIN_AW-1:0]   addr;    // key for queries
        logic [`PROT_DW-1:0]        value;
        logic [`PROT_DW-1:0]        exp_val;
    } row_t;

    logic                clk;
    logic                reset;
    prot_pkg::main_bus_t main;
    prot_pkg::byte_t     main_din;
    prot_pkg::prog_t     prog;

    row_t        rows [NUM_ROWS];
    int          n_rows;
    logic [7:0]  rom_model [512];   // copy of the downloaded image
    logic [7:0]  cnt_model [256];   // queries seen per key
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          row_errors;

    prot_top i_dut (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .main     ( main     ),
        .main_din ( main_din ),
        .prog     ( prog     )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        b = 8'h00;
        for (int k = 0; k < 8; k++) begin
            b    = {lfsr[0], b[7:1]};   // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp_val,
                               input string what);
        checks++;
        if (got !== exp_val) begin
            $display("FAIL %0t: %s, got %02h expected %02h", $time, what, got, exp_val);
            errors++;
            row_errors++;
        end
    endtask

    task automatic add_row(input logic [2:0] op, input logic [10:0] addr,
                           input logic [7:0] value, input logic [7:0] exp_val);
        rows[n_rows] = {op, addr, value, exp_val};
        n_rows++;
    endtask

    function automatic string op_name(input logic [2:0] op);
        case (op)
            OP_LOAD:      op_name = "load ";
            OP_WRITE:     op_name = "write";
            OP_READ:      op_name = "read ";
            OP_QUERY:     op_name = "query";
            default:      op_name = "rstq ";
        endcase
    endfunction

    // one main cycle with cs high, then idle
    task automatic main_write(input logic [10:0] addr, input logic [7:0] data);
        @(negedge clk);
        main.addr  = addr;
        main.wdata = data;
        main.cs    = 1'b1;
        main.wrn   = 1'b0;
        @(negedge clk);
        main.cs    = 1'b0;
        main.wrn   = 1'b1;
    endtask

    task automatic main_read(input logic [10:0] addr, output logic [7:0] data);
        @(negedge clk);
        main.addr = addr;
        main.cs   = 1'b1;
        main.wrn  = 1'b1;
        @(negedge clk);
        data      = main_din;   // captured on the edge in between
        main.cs   = 1'b0;
    endtask

    task automatic download_rom();
        logic [7:0] b;
        for (int a = 0; a < 512; a++) begin
            rand_byte(b);
            rom_model[a] = b;
            @(negedge clk);
            prog.addr = a[8:0];
            prog.data = b;
            prog.en   = 1'b1;
        end
        @(negedge clk);
        prog.en = 1'b0;
    endtask

    task automatic run_query(input logic [7:0] key, input logic [7:0] exp_stat);
        logic [7:0] d;
        logic [7:0] exp_res;
        int         polls;
        exp_res = rom_model[{1'b0, key}] + cnt_model[key];   // wraps at 256
        main_write(`PROT_KEY_OFS, key);
        main_write(`PROT_STAT_OFS, 8'h00);
        main_write(`PROT_DOORBELL, 8'h01);   // any value rings
        polls = 0;
        d     = 8'h00;
        while (d !== exp_stat && polls < POLL_LIMIT) begin
            main_read(`PROT_STAT_OFS, d);
            polls++;
        end
        if (d !== exp_stat) begin
            $display("key %02h: status byte never showed the done marker after %0d polls",
                     key, polls);
        end
        check_value(d, exp_stat, "status byte");
        if (d === exp_stat) begin
            main_read(`PROT_RES_OFS, d);
            check_value(d, exp_res, $sformatf("result for key %02h", key));
        end
        cnt_model[key] = cnt_model[key] + 8'd1;
    endtask

    task automatic run_row(input int idx);
        row_t       r;
        logic [7:0] d;
        r          = rows[idx];
        row_errors = 0;
        case (r.op)
            OP_LOAD: download_rom();
            OP_WRITE: begin
                main_write(r.addr, r.value);
                main_read(r.addr, d);
                check_value(d, r.exp_val, $sformatf("readback at %03h", r.addr));
            end
            OP_READ: begin
                main_read(r.addr, d);
                check_value(d, r.exp_val, $sformatf("read at %03h", r.addr));
            end
            OP_QUERY: run_query(r.addr[7:0], r.exp_val);
            default: begin
                @(negedge clk);
                reset = 1'b1;
                repeat (3) @(negedge clk);
                reset = 1'b0;
                for (int k = 0; k < 256; k++) begin
                    cnt_model[k] = 8'h00;   // engine clears its counts
                end
                run_query(r.addr[7:0], r.exp_val);   // rings while clearing
            end
        endcase
        $display("row %0d %s %03h: %s", idx, op_name(r.op), r.addr,
                 (row_errors == 0) ? "ok" : "mismatch");
    endtask

    task automatic build_table();
        n_rows = 0;
        add_row(OP_LOAD,      11'h000, 8'h00, 8'h00);
        add_row(OP_QUERY,     11'h012, 8'h00, `PROT_DONE);   // first use of a key
        add_row(OP_QUERY,     11'h012, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h012, 8'h00, `PROT_DONE);
        add_row(OP_WRITE,     11'h123, 8'h5a, 8'h5a);
        add_row(OP_WRITE,     11'h7fe, 8'hc3, 8'hc3);        // just below the doorbell
        add_row(OP_WRITE,     11'h400, 8'h01, 8'h01);
        add_row(OP_READ,      11'h123, 8'h00, 8'h5a);
        add_row(OP_QUERY,     11'h080, 8'h00, `PROT_DONE);   // interleaved keys
        add_row(OP_QUERY,     11'h0ff, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h012, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h080, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h000, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h0ff, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h080, 8'h00, `PROT_DONE);
        add_row(OP_READ,      11'h400, 8'h00, 8'h01);
        add_row(OP_READ,      11'h7fe, 8'h00, 8'hc3);
        add_row(OP_RST_QUERY, 11'h012, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h012, 8'h00, `PROT_DONE);
        add_row(OP_QUERY,     11'h080, 8'h00, `PROT_DONE);
    endtask

    initial begin
        main      = '0;
        main.wrn  = 1'b1;
        prog      = '0;
        reset     = 1'b1;
        lfsr      = 16'd18194;
        errors    = 0;
        checks    = 0;
        for (int k = 0; k < 256; k++) begin
            cnt_model[k] = 8'h00;
        end
        build_table();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (260) @(negedge clk);   // let the 256 entry clear finish
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (NUM_ROWS * 400 + 600) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles, stopped",
                 NUM_ROWS * 400 + 600);
        $display("test failed");
        $finish;
    end

endmodule

/* prot_top.f */
+incdir+rtl
rtl/prot_pkg.sv
rtl/prot_mem.sv
rtl/prot_shared_ram.sv
rtl/prot_decode.sv
rtl/prot_engine.sv
rtl/prot_top.sv
test/prot_tb.sv

/* Bender.yml */
package:
  name: prot_top

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/prot_pkg.sv
      - rtl/prot_mem.sv
      - rtl/prot_shared_ram.sv
      - rtl/prot_decode.sv
      - rtl/prot_engine.sv
      - rtl/prot_top.sv
  - target: test
    files:
      - test/prot_tb.sv
